// File: src/eth_tx_pkg.sv
`default_nettype none

package eth_tx_pkg;

    //////////////////////////////
    // Width types
    //////////////////////////////
    typedef logic [7:0]  byte_t;        // One byte on the wire
    typedef logic [31:0] crc_t;         // CRC register and FCS
    typedef logic [10:0] len_t;         // Payload plus pad count, saturates
    typedef logic [10:0] gap_t;         // Phase byte index and gap cycles
    typedef logic [1:0]  link_speed_t;  // 00 10M, 01 100M, 1x 1G
    typedef logic [1:0]  fcs_idx_t;     // FCS byte number, LSB first

    // Frame sequencing states
    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        SFD,
        PAYLOAD,
        PADDING,
        FCS,
        GAP
    } tx_state_t;

    // Source of the next byte on tx_data
    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_PREAMBLE,
        SEL_SFD,
        SEL_DATA,
        SEL_PAD,
        SEL_FCS
    } byte_sel_t;

    //////////////////////////////
    // Ethernet constants
    //////////////////////////////
    localparam byte_t ETH_PREAMBLE = 8'h55;
    localparam byte_t ETH_SFD      = 8'hD5;
    localparam byte_t ETH_PAD      = 8'h00;

    localparam crc_t CRC_INIT = 32'hFFFF_FFFF;
    localparam crc_t CRC_POLY = 32'hEDB8_8320;  // Reflected 802.3 polynomial

    localparam gap_t PREAMBLE_BYTES = 11'd7;

    // 96 bit times at 125 MHz for each link rate
    localparam gap_t GAP_10M  = 11'd1200;
    localparam gap_t GAP_100M = 11'd120;
    localparam gap_t GAP_1G   = 11'd12;

endpackage

`default_nettype wire

// File: src/crc32_engine.sv
`timescale 1ns/1ps
`default_nettype none

module crc32_engine import eth_tx_pkg::*; (
    input  wire logic clk,
    input  wire logic reset_n,
    input  wire logic tx_rdy,      // Low freezes the register
    input  wire logic crc_clear,   // Restart at CRC_INIT
    input  wire logic crc_en,      // Fold in frame_byte
    input  wire byte_t frame_byte,
    output crc_t      fcs
);

    crc_t crc_q;  // Running reflected remainder

    // One byte, LSB first, eight shift steps
    function automatic crc_t crc_step(input crc_t c, input byte_t d);
        crc_t r;
        r = c;
        for (int i = 0; i < 8; i++) begin
            if (r[0] ^ d[i])
                r = (r >> 1) ^ CRC_POLY;
            else
                r = r >> 1;
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (reset_n) begin
            crc_q <= CRC_INIT;
        end else if (tx_rdy) begin
            if (crc_clear)
                crc_q <= CRC_INIT;                  // Start of frame
            else if (crc_en)
                crc_q <= crc_step(crc_q, frame_byte);
        end
    end

    // Final complement, held while crc_en is low
    assign fcs = ~crc_q;

endmodule

`default_nettype wire

// File: src/tx_frame_counter.sv
`timescale 1ns/1ps
`default_nettype none

module tx_frame_counter import eth_tx_pkg::*; #(
    parameter int MIN_FRAME_BYTES = 60  // Minimum payload plus pad
) (
    input  wire logic        clk,
    input  wire logic        reset_n,
    input  wire logic        tx_rdy,
    input  wire tx_state_t   state,
    input  wire link_speed_t link_speed,
    output logic             phase_last,       // Terminal count of the phase
    output logic             len_min_reached,  // This byte completes the minimum
    output fcs_idx_t         fcs_idx
);

    gap_t idx_q;    // Byte index inside PREAMBLE, FCS or GAP
    len_t len_q;    // Bytes of payload plus pad already sent
    gap_t gap_len;  // Gap length for the current link rate

    // Gap length by link speed
    always_comb begin
        case (link_speed)
            2'b00:   gap_len = GAP_10M;
            2'b01:   gap_len = GAP_100M;
            default: gap_len = GAP_1G;   // 10 and 11 both gigabit
        endcase
    end

    // Terminal count decode
    always_comb begin
        case (state)
            PREAMBLE: phase_last = (idx_q == PREAMBLE_BYTES - 11'd1);
            FCS:      phase_last = (idx_q == 11'd3);
            GAP:      phase_last = (idx_q == gap_len - 11'd1);
            default:  phase_last = 1'b0;
        endcase
    end

    assign len_min_reached = (len_q >= len_t'(MIN_FRAME_BYTES - 1));
    assign fcs_idx         = idx_q[1:0];  // FCS phase never exceeds 3

    //////////////////////////////
    // Counters
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_n) begin
            idx_q <= '0;
            len_q <= '0;
        end else if (tx_rdy) begin
            // Index restarts whenever the phase ends
            if (phase_last)
                idx_q <= '0;
            else if (state == PREAMBLE || state == FCS || state == GAP)
                idx_q <= idx_q + 11'd1;
            else
                idx_q <= '0;                        // Other phases leave it at zero

            if (state == IDLE)
                len_q <= '0;
            else if ((state == PAYLOAD || state == PADDING) && len_q != '1)
                len_q <= len_q + 11'd1;             // Saturating
        end
    end

endmodule

`default_nettype wire

// File: src/tx_frame_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module tx_frame_fsm import eth_tx_pkg::*; (
    input  wire logic clk,
    input  wire logic reset_n,
    input  wire logic tx_rdy,            // PHY advance strobe
    input  wire logic s_tx_axis_tvalid,
    input  wire logic s_tx_axis_tlast,
    input  wire logic phase_last,
    input  wire logic len_min_reached,
    output tx_state_t state,
    output byte_sel_t byte_sel,
    output logic      s_tx_axis_trdy,
    output logic      crc_clear,
    output logic      crc_en,
    output logic      tx_dv,
    output logic      tx_er
);

    tx_state_t state_next;
    logic      dv_next;  // Valid flag for the byte loaded this edge
    logic      er_next;  // Error flag for the byte loaded this edge

    // FIFO may hand over a byte only in PAYLOAD and while the PHY advances
    assign s_tx_axis_trdy = (state == PAYLOAD) && tx_rdy;

    //////////////////////////////
    // Next state and byte control
    //////////////////////////////
    always_comb begin
        state_next = state;
        byte_sel   = SEL_NONE;
        crc_clear  = 1'b0;
        crc_en     = 1'b0;
        dv_next    = 1'b0;
        er_next    = 1'b0;

        case (state)
            IDLE: begin
                if (s_tx_axis_tvalid) begin
                    crc_clear  = 1'b1;        // Fresh CRC per frame
                    state_next = PREAMBLE;
                end
            end
            PREAMBLE: begin
                byte_sel = SEL_PREAMBLE;
                dv_next  = 1'b1;
                if (phase_last)
                    state_next = SFD;
            end
            SFD: begin
                byte_sel   = SEL_SFD;
                dv_next    = 1'b1;
                state_next = PAYLOAD;
            end
            PAYLOAD: begin
                dv_next = 1'b1;
                if (s_tx_axis_tvalid) begin
                    byte_sel = SEL_DATA;
                    crc_en   = 1'b1;
                    if (s_tx_axis_tlast)
                        state_next = len_min_reached ? FCS : PADDING;
                end else begin
                    // Underrun, flag this byte and skip the FCS
                    byte_sel   = SEL_PAD;
                    er_next    = 1'b1;
                    state_next = GAP;
                end
            end
            PADDING: begin
                byte_sel = SEL_PAD;
                crc_en   = 1'b1;              // Pad is covered by the FCS
                dv_next  = 1'b1;
                if (len_min_reached)
                    state_next = FCS;
            end
            FCS: begin
                byte_sel = SEL_FCS;
                dv_next  = 1'b1;
                if (phase_last)
                    state_next = GAP;
            end
            GAP: begin
                if (phase_last)
                    state_next = IDLE;        // Line idle long enough
            end
            default: state_next = IDLE;
        endcase
    end

    // State and line flags, all frozen while tx_rdy is low
    always_ff @(posedge clk) begin
        if (reset_n) begin
            state <= IDLE;
            tx_dv <= 1'b0;
            tx_er <= 1'b0;
        end else if (tx_rdy) begin
            state <= state_next;
            tx_dv <= dv_next;   // Lines up with tx_data in the mux
            tx_er <= er_next;
        end
    end

endmodule

`default_nettype wire

// File: src/tx_byte_mux.sv
`timescale 1ns/1ps
`default_nettype none

module tx_byte_mux import eth_tx_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset_n,
    input  wire logic      tx_rdy,
    input  wire byte_sel_t byte_sel,
    input  wire byte_t     s_tx_axis_tdata,
    input  wire crc_t      fcs,
    input  wire fcs_idx_t  fcs_idx,
    output byte_t          frame_byte,  // Byte the CRC absorbs
    output byte_t          tx_data
);

    byte_t byte_next;  // Value loaded into tx_data at the next advance

    // Only payload or pad reaches the CRC
    assign frame_byte = (byte_sel == SEL_DATA) ? s_tx_axis_tdata : ETH_PAD;

    //////////////////////////////
    // Byte select
    //////////////////////////////
    always_comb begin
        case (byte_sel)
            SEL_PREAMBLE: byte_next = ETH_PREAMBLE;
            SEL_SFD:      byte_next = ETH_SFD;
            SEL_DATA:     byte_next = s_tx_axis_tdata;
            SEL_PAD:      byte_next = ETH_PAD;
            SEL_FCS:      byte_next = fcs[8*fcs_idx +: 8];  // LSB first
            default:      byte_next = ETH_PAD;              // Idle line
        endcase
    end

    // Single output stage
    always_ff @(posedge clk) begin
        if (reset_n)
            tx_data <= '0;
        else if (tx_rdy)
            tx_data <= byte_next;
    end

endmodule

`default_nettype wire

// File: src/eth_tx_mac.sv
`timescale 1ns/1ps
`default_nettype none

module eth_tx_mac import eth_tx_pkg::*; #(
    parameter int MIN_FRAME_BYTES = 60
) (
    input  wire logic        clk,
    input  wire logic        reset_n,

    // FIFO side
    input  wire byte_t       s_tx_axis_tdata,
    input  wire logic        s_tx_axis_tvalid,
    input  wire logic        s_tx_axis_tlast,
    output logic             s_tx_axis_trdy,

    // PHY side
    input  wire logic        tx_rdy,
    output byte_t            tx_data,
    output logic             tx_dv,
    output logic             tx_er,

    // Configuration
    input  wire link_speed_t link_speed
);

    tx_state_t state;
    byte_sel_t byte_sel;
    fcs_idx_t  fcs_idx;
    logic      phase_last;
    logic      len_min_reached;
    logic      crc_clear;
    logic      crc_en;
    byte_t     frame_byte;   // Payload or pad into the CRC
    crc_t      fcs;

    //////////////////////////////
    // Sequencing
    //////////////////////////////
    tx_frame_fsm u_fsm (
        .clk              (clk),
        .reset_n          (reset_n),
        .tx_rdy           (tx_rdy),
        .s_tx_axis_tvalid (s_tx_axis_tvalid),
        .s_tx_axis_tlast  (s_tx_axis_tlast),
        .phase_last       (phase_last),
        .len_min_reached  (len_min_reached),
        .state            (state),
        .byte_sel         (byte_sel),
        .s_tx_axis_trdy   (s_tx_axis_trdy),
        .crc_clear        (crc_clear),
        .crc_en           (crc_en),
        .tx_dv            (tx_dv),
        .tx_er            (tx_er)
    );

    tx_frame_counter #(
        .MIN_FRAME_BYTES (MIN_FRAME_BYTES)
    ) u_counter (
        .clk             (clk),
        .reset_n         (reset_n),
        .tx_rdy          (tx_rdy),
        .state           (state),
        .link_speed      (link_speed),
        .phase_last      (phase_last),
        .len_min_reached (len_min_reached),
        .fcs_idx         (fcs_idx)
    );

    //////////////////////////////
    // Datapath
    //////////////////////////////
    tx_byte_mux u_mux (
        .clk             (clk),
        .reset_n         (reset_n),
        .tx_rdy          (tx_rdy),
        .byte_sel        (byte_sel),
        .s_tx_axis_tdata (s_tx_axis_tdata),
        .fcs             (fcs),
        .fcs_idx         (fcs_idx),
        .frame_byte      (frame_byte),
        .tx_data         (tx_data)
    );

    crc32_engine u_crc (
        .clk        (clk),
        .reset_n    (reset_n),
        .tx_rdy     (tx_rdy),
        .crc_clear  (crc_clear),
        .crc_en     (crc_en),
        .frame_byte (frame_byte),
        .fcs        (fcs)
    );

endmodule

`default_nettype wire

// File: tb/eth_tx_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module eth_tx_assertions (
    input wire logic       clk,
    input wire logic       reset_n,
    input wire logic       tx_rdy,
    input wire logic [7:0] tx_data,
    input wire logic       tx_dv,
    input wire logic       tx_er,
    input wire logic       s_tx_axis_trdy
);

    int fail_count = 0;  // Number of failed protocol checks

    //////////////////////////////
    // Reset behavior
    //////////////////////////////
    // Line quiet during reset and on the cycle after it
    reset_quiet: assert property (@(posedge clk)
        reset_n |=> (!tx_dv && !tx_er && !s_tx_axis_trdy))
        else begin
            $error("Line or FIFO ready active during or right after reset");
            fail_count++;
        end

    //////////////////////////////
    // Line protocol
    //////////////////////////////
    er_needs_dv: assert property (@(posedge clk) disable iff (reset_n)
        tx_er |-> tx_dv)
        else begin
            $error("tx_er high without tx_dv");
            fail_count++;
        end

    // FIFO is only read while bytes go out
    trdy_needs_dv: assert property (@(posedge clk) disable iff (reset_n)
        s_tx_axis_trdy |-> tx_dv)
        else begin
            $error("s_tx_axis_trdy high while tx_dv is low");
            fail_count++;
        end

    // PHY pause freezes the line
    hold_on_pause: assert property (@(posedge clk) disable iff (reset_n)
        !tx_rdy |=> ($stable(tx_data) && $stable(tx_dv) && $stable(tx_er)))
        else begin
            $error("Line outputs changed while tx_rdy was low");
            fail_count++;
        end

endmodule

bind eth_tx_mac eth_tx_assertions u_assert (
    .clk            (clk),
    .reset_n        (reset_n),
    .tx_rdy         (tx_rdy),
    .tx_data        (tx_data),
    .tx_dv          (tx_dv),
    .tx_er          (tx_er),
    .s_tx_axis_trdy (s_tx_axis_trdy)
);

`default_nettype wire

// File: tb/tb_eth_tx_mac.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eth_tx_mac;

    localparam int          CLK_PERIOD      = 40;
    localparam int          MIN_FRAME_BYTES = 60;
    localparam logic [31:0] SEED            = 32'h27f0_5e03;
    localparam logic [31:0] CRC32_POLY      = 32'hEDB8_8320;  // Reflected 802.3

    // Line cycles of all tests as frame bytes plus gap in test order
    localparam int WIRE_CYCLES = 104 + 84 + 84 + 84 + 94 + 168 + 384 + 2544 + 41 + 84;
    localparam int WATCHDOG_NS = (WIRE_CYCLES * 4 + 2000) * CLK_PERIOD;

    logic       clk              = 1'b0;
    logic       reset_n          = 1'b1;   // Active high
    logic [7:0] s_tx_axis_tdata  = 8'h00;
    logic       s_tx_axis_tvalid = 1'b0;
    logic       s_tx_axis_tlast  = 1'b0;
    logic       s_tx_axis_trdy;
    logic       tx_rdy           = 1'b1;
    logic [7:0] tx_data;
    logic       tx_dv;
    logic       tx_er;
    logic [1:0] link_speed       = 2'b10;  // Gigabit

    // FIFO model and PHY pause pattern
    logic [8:0] fifo_q[$];                 // {tlast, tdata}
    logic       xfer_seen = 1'b0;          // Byte taken at the last edge
    logic       stall_en  = 1'b0;
    logic       stall_pat [1024];
    logic [9:0] stall_idx = '0;

    // Reference and collected frames
    logic [7:0] payload[$];
    logic [7:0] exp_frame[$];
    logic [7:0] rx_cur[$];
    logic [7:0] rx_frame[$];
    int         rx_er_cur[$];              // Byte positions with tx_er
    int         rx_er[$];
    int         rx_frames = 0;
    int         low_run   = 0;             // Advancing edges with tx_dv low
    int         last_gap  = 0;             // Idle run before the latest frame

    string cur_test;
    int    test_errors  = 0;
    int    errors       = 0;
    int    checks       = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;

    eth_tx_mac #(
        .MIN_FRAME_BYTES (MIN_FRAME_BYTES)
    ) u_dut (
        .clk              (clk),
        .reset_n          (reset_n),
        .s_tx_axis_tdata  (s_tx_axis_tdata),
        .s_tx_axis_tvalid (s_tx_axis_tvalid),
        .s_tx_axis_tlast  (s_tx_axis_tlast),
        .s_tx_axis_trdy   (s_tx_axis_trdy),
        .tx_rdy           (tx_rdy),
        .tx_data          (tx_data),
        .tx_dv            (tx_dv),
        .tx_er            (tx_er),
        .link_speed       (link_speed)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////
    // FIFO and PHY drive on the falling edge
    //////////////////////////////
    always @(negedge clk) begin
        if (xfer_seen)
            void'(fifo_q.pop_front());     // MAC took the front byte
        if (fifo_q.size() != 0) begin
            s_tx_axis_tvalid = 1'b1;
            s_tx_axis_tdata  = fifo_q[0][7:0];
            s_tx_axis_tlast  = fifo_q[0][8];
        end else begin
            s_tx_axis_tvalid = 1'b0;       // Empty FIFO
            s_tx_axis_tdata  = 8'h00;
            s_tx_axis_tlast  = 1'b0;
        end
        tx_rdy    = stall_en ? stall_pat[stall_idx] : 1'b1;
        stall_idx = stall_idx + 10'd1;
    end

    //////////////////////////////
    // Line monitor on the rising edge
    //////////////////////////////
    always @(posedge clk) begin
        xfer_seen = s_tx_axis_trdy && s_tx_axis_tvalid;
        if (!reset_n && tx_rdy) begin
            if (tx_dv) begin
                if (low_run != 0)
                    last_gap = low_run;    // Frame start after idle
                low_run = 0;
                if (tx_er)
                    rx_er_cur.push_back(rx_cur.size());
                rx_cur.push_back(tx_data);
            end else begin
                if (rx_cur.size() != 0) begin
                    rx_frame = rx_cur;     // Falling tx_dv ends the frame
                    rx_er    = rx_er_cur;
                    rx_cur.delete();
                    rx_er_cur.delete();
                    rx_frames++;
                end
                low_run++;
            end
        end
    end

    // Gap length per link speed
    function automatic int gap_cycles(input logic [1:0] speed);
        int n;
        case (speed)
            2'b00:   n = 1200;
            2'b01:   n = 120;
            default: n = 12;
        endcase
        return n;
    endfunction

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        $display("Test %s done, %0d errors", cur_test, test_errors);
    endtask

    task automatic check_value(input string what, input int expv, input int actv);
        checks++;
        assert (actv == expv) else begin
            $display("FAILED %s %s: expected %0h, actual %0h", cur_test, what, expv, actv);
            test_errors++;
            errors++;
        end
    endtask

    task automatic check_at_least(input string what, input int minv, input int actv);
        checks++;
        assert (actv >= minv) else begin
            $display("FAILED %s %s: expected at least %0d, actual %0d",
                     cur_test, what, minv, actv);
            test_errors++;
            errors++;
        end
    endtask

    task automatic make_payload(input int len);
        payload.delete();
        for (int i = 0; i < len; i++)
            payload.push_back(8'($urandom));
    endtask

    // Preamble, SFD, body, then FCS or a single error byte
    task automatic build_expected(input bit complete);
        logic [7:0]  body[$];
        logic [31:0] crc;
        exp_frame.delete();
        repeat (7) exp_frame.push_back(8'h55);
        exp_frame.push_back(8'hD5);
        foreach (payload[i])
            body.push_back(payload[i]);
        if (complete) begin
            while (body.size() < MIN_FRAME_BYTES)
                body.push_back(8'h00);     // Pad to the minimum
        end
        foreach (body[i])
            exp_frame.push_back(body[i]);
        if (!complete) begin
            exp_frame.push_back(8'h00);    // Aborted byte flagged by tx_er
        end else begin
            crc = 32'hFFFF_FFFF;
            foreach (body[i]) begin
                crc = crc ^ {24'h0, body[i]};
                repeat (8) crc = crc[0] ? ((crc >> 1) ^ CRC32_POLY) : (crc >> 1);
            end
            crc = ~crc;
            for (int k = 0; k < 4; k++)
                exp_frame.push_back(crc[8*k +: 8]);  // LSB first
        end
    endtask

    // Queue the payload into the FIFO model
    task automatic push_payload(input bit with_last);
        @(posedge clk);
        foreach (payload[i])
            fifo_q.push_back({with_last && (i == payload.size() - 1), payload[i]});
    endtask

    task automatic wait_frames(input int target);
        while (rx_frames < target)
            @(negedge clk);
    endtask

    // Line back in IDLE before the next test
    task automatic wait_line_idle();
        while (low_run < gap_cycles(link_speed) + 2)
            @(negedge clk);
    endtask

    task automatic compare_frame();
        int n;
        check_value("frame length", exp_frame.size(), rx_frame.size());
        n = (exp_frame.size() < rx_frame.size()) ? exp_frame.size() : rx_frame.size();
        for (int i = 0; i < n; i++) begin
            check_value($sformatf("byte %0d", i), exp_frame[i], rx_frame[i]);
            if (rx_frame[i] !== exp_frame[i])
                break;                     // First mismatch is enough
        end
    endtask

    task automatic run_frame(input string name, input int len);
        int target;
        start_test(name);
        make_payload(len);
        build_expected(1'b1);
        target = rx_frames + 1;
        push_payload(1'b1);
        wait_frames(target);
        compare_frame();
        check_value("tx_er bytes", 0, rx_er.size());
        wait_line_idle();
        finish_test();
    endtask

    // Two frames back to back with the idle run between them
    task automatic measure_gap(input string name, input logic [1:0] speed);
        int target;
        start_test(name);
        @(negedge clk);
        link_speed = speed;
        make_payload(20);
        build_expected(1'b1);
        target = rx_frames + 2;
        push_payload(1'b1);
        push_payload(1'b1);
        wait_frames(target - 1);
        compare_frame();
        wait_frames(target);
        compare_frame();
        check_at_least("idle edges", gap_cycles(speed), last_gap);
        wait_line_idle();
        finish_test();
    endtask

    task automatic run_underrun();
        int target;
        start_test("underrun_20");
        @(negedge clk);
        link_speed = 2'b10;
        make_payload(20);
        build_expected(1'b0);
        target = rx_frames + 1;
        push_payload(1'b0);                // No tlast so the FIFO runs dry
        wait_frames(target);
        compare_frame();
        check_value("tx_er bytes", 1, rx_er.size());
        if (rx_er.size() == 1)
            check_value("tx_er position", 28, rx_er[0]);
        wait_line_idle();
        finish_test();
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin
        void'($urandom(SEED));
        for (int i = 0; i < 1024; i++)
            stall_pat[i] = ($urandom % 100) >= 30;  // About 30% pause
        repeat (16) @(negedge clk);
        reset_n = 1'b0;
        repeat (4) @(negedge clk);

        run_frame("payload_80", 80);
        run_frame("pad_10", 10);
        run_frame("no_pad_60", 60);
        @(posedge clk);
        stall_en = 1'b1;
        run_frame("stall_40", 40);
        run_frame("stall_70", 70);
        @(posedge clk);
        stall_en = 1'b0;
        measure_gap("gap_1g", 2'b10);
        measure_gap("gap_100m", 2'b01);
        measure_gap("gap_10m", 2'b00);
        run_underrun();
        run_frame("after_underrun_30", 30);

        if (u_dut.u_assert.fail_count != 0) begin
            $display("Protocol assertions fired %0d times", u_dut.u_assert.fail_count);
            errors += u_dut.u_assert.fail_count;
        end
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
src/eth_tx_pkg.sv
src/crc32_engine.sv
src/tx_frame_counter.sv
src/tx_frame_fsm.sv
src/tx_byte_mux.sv
src/eth_tx_mac.sv
tb/eth_tx_assertions.sv
tb/tb_eth_tx_mac.sv

// File: Bender.yml
package:
  name: eth_tx_mac

sources:
  - src/eth_tx_pkg.sv
  - src/crc32_engine.sv
  - src/tx_frame_counter.sv
  - src/tx_frame_fsm.sv
  - src/tx_byte_mux.sv
  - src/eth_tx_mac.sv
  - target: simulation
    files:
      - tb/eth_tx_assertions.sv
      - tb/tb_eth_tx_mac.sv
